// File: Bender.yml
package:
  name: muldiv_unit

sources:
  - common/muldiv_pkg.sv
  - multiplier/pipe_multiplier.sv
  - divider/serial_divider.sv
  - rtl/commit_arbiter.sv
  - rtl/muldiv_unit.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/muldiv_asserts.sv
      - tests/muldiv_tb.sv

// File: common/muldiv_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared types for the integer multiply/divide execute unit.
// Only 32-bit operation is supported; W-form instructions are absent.
// MUL_LATENCY must be at least 2 for the multiplier pipeline.
//////////////////////////////////////////////////////////////////////

package muldiv_pkg;

    localparam int XLEN        = 32;
    localparam int NUM_LANES   = 2;
    localparam int NUM_WARPS   = 4;
    localparam int NUM_REGS    = 32;
    localparam int MUL_LATENCY = 3;
    // One setup cycle followed by one iteration per operand bit
    localparam int DIV_CYCLES  = 33;

    localparam int WID_BITS = $clog2(NUM_WARPS);
    localparam int REG_BITS = $clog2(NUM_REGS);

    // Product half and operand signedness for the multiply class
    typedef enum logic [1:0] {
        MUL_LO  = 2'b00,
        MUL_HSS = 2'b01,
        MUL_HSU = 2'b10,
        MUL_HUU = 2'b11
    } mul_sel_e;

    typedef struct packed {
        logic     is_div;
        mul_sel_e sel;
    } mul_view_t;

    typedef struct packed {
        logic is_div;
        logic is_rem;
        logic is_unsigned;
    } div_view_t;

    // The funct3 field, read differently by the two datapaths
    typedef union packed {
        mul_view_t mul;
        div_view_t div;
    } muldiv_op_u;

    typedef logic [NUM_LANES-1:0][XLEN-1:0] lane_data_t;

    typedef struct packed {
        logic [WID_BITS-1:0]  wid;
        logic [NUM_LANES-1:0] tmask;
        logic [REG_BITS-1:0]  rd;
        logic                 wb;
        logic                 sop;
        logic                 eop;
    } muldiv_tag_t;

    typedef struct packed {
        muldiv_tag_t tag;
        muldiv_op_u  op;
        lane_data_t  rs1_data;
        lane_data_t  rs2_data;
    } muldiv_req_t;

    typedef struct packed {
        muldiv_tag_t tag;
        lane_data_t  data;
    } commit_rsp_t;

endpackage

// File: divider/serial_divider.sv
//////////////////////////////////////////////////////////////////////
// Restoring divider, one request at a time, all lanes in lockstep.
// Takes DIV_CYCLES from accept to result; the result is held until
// it is taken, and no new request is accepted meanwhile.
// Divide by zero and signed overflow follow the RISC-V M rules.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module serial_divider (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  muldiv_pkg::muldiv_req_t  req,
    output logic                     out_valid,
    input  logic                     out_ready,
    output muldiv_pkg::commit_rsp_t  rsp
);

    localparam int XW     = muldiv_pkg::XLEN;
    localparam int LANES  = muldiv_pkg::NUM_LANES;
    localparam int CNT_W  = $clog2(muldiv_pkg::DIV_CYCLES);
    localparam int FIX_AT = muldiv_pkg::DIV_CYCLES - 1;

    logic             busy;
    logic             full;
    logic [CNT_W-1:0] cnt;
    logic             accept;
    logic             fixup;
    logic             is_signed;

    muldiv_pkg::muldiv_tag_t tag_q;
    logic                    rem_sel_q;
    muldiv_pkg::lane_data_t  result_q;

    logic [LANES-1:0][XW-1:0] rem_q;
    logic [LANES-1:0][XW-1:0] quo_q;
    logic [LANES-1:0][XW-1:0] den_q;
    logic [LANES-1:0]         q_neg_q;
    logic [LANES-1:0]         r_neg_q;

    logic [LANES-1:0][XW-1:0] mag_a;
    logic [LANES-1:0][XW-1:0] mag_b;
    logic [LANES-1:0][XW:0]   shifted;
    logic [LANES-1:0][XW:0]   diff;
    logic [LANES-1:0]         take;
    logic [LANES-1:0][XW-1:0] rem_nxt;
    logic [LANES-1:0][XW-1:0] quo_nxt;
    logic [LANES-1:0][XW-1:0] rem_fix;
    logic [LANES-1:0][XW-1:0] quo_fix;

    assign in_ready  = !busy && !full;
    assign accept    = in_valid && in_ready;
    assign fixup     = busy && (cnt == CNT_W'(FIX_AT));
    assign is_signed = !req.op.div.is_unsigned;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            mag_a[i] = (is_signed && req.rs1_data[i][XW-1]) ? -req.rs1_data[i]
                                                            : req.rs1_data[i];
            mag_b[i] = (is_signed && req.rs2_data[i][XW-1]) ? -req.rs2_data[i]
                                                            : req.rs2_data[i];

            // One restoring step: bring in the next dividend bit and try to subtract
            shifted[i] = {rem_q[i], quo_q[i][XW-1]};
            diff[i]    = shifted[i] - {1'b0, den_q[i]};
            take[i]    = (shifted[i] >= {1'b0, den_q[i]});
            rem_nxt[i] = take[i] ? diff[i][XW-1:0] : shifted[i][XW-1:0];
            quo_nxt[i] = {quo_q[i][XW-2:0], take[i]};

            quo_fix[i] = q_neg_q[i] ? -quo_q[i] : quo_q[i];
            rem_fix[i] = r_neg_q[i] ? -rem_q[i] : rem_q[i];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            full <= 1'b0;
            cnt  <= '0;
        end else begin
            if (full && out_ready) begin
                full <= 1'b0;
            end
            if (accept) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (fixup) begin
                busy <= 1'b0;
                full <= 1'b1;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tag_q     <= req.tag;
            rem_sel_q <= req.op.div.is_rem;
            for (int i = 0; i < LANES; i++) begin
                quo_q[i] <= mag_a[i];
                den_q[i] <= mag_b[i];
                rem_q[i] <= '0;
                // A zero divisor leaves the all-ones quotient magnitude unsigned
                q_neg_q[i] <= is_signed && (req.rs1_data[i][XW-1] ^ req.rs2_data[i][XW-1])
                              && (req.rs2_data[i] != '0);
                r_neg_q[i] <= is_signed && req.rs1_data[i][XW-1];
            end
        end else if (fixup) begin
            // MIN / -1 needs no special case: the negated magnitude wraps back to MIN
            for (int i = 0; i < LANES; i++) begin
                result_q[i] <= rem_sel_q ? rem_fix[i] : quo_fix[i];
            end
        end else if (busy) begin
            rem_q <= rem_nxt;
            quo_q <= quo_nxt;
        end
    end

    assign out_valid = full;
    assign rsp.tag   = tag_q;
    assign rsp.data  = result_q;

endmodule

// File: multiplier/pipe_multiplier.sv
//////////////////////////////////////////////////////////////////////
// Pipelined multiplier, MUL_LATENCY stages, all lanes in parallel.
// The whole pipeline stalls together; it never drops a bubble.
// Operands are widened to XLEN+1 bits so one signed multiply
// serves all four product forms.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pipe_multiplier (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  muldiv_pkg::muldiv_req_t  req,
    output logic                     out_valid,
    input  logic                     out_ready,
    output muldiv_pkg::commit_rsp_t  rsp
);

    localparam int LAST = muldiv_pkg::MUL_LATENCY - 1;
    localparam int XW   = muldiv_pkg::XLEN;
    localparam int PW   = 2 * (muldiv_pkg::XLEN + 1);

    logic enable;
    logic a_signed;
    logic b_signed;

    logic [LAST:0]                            valid_q;
    logic [LAST:0]                            high_q;
    muldiv_pkg::muldiv_tag_t [LAST:0]         tag_q;
    logic [muldiv_pkg::NUM_LANES-1:0][XW:0]   a_q;
    logic [muldiv_pkg::NUM_LANES-1:0][XW:0]   b_q;
    logic [muldiv_pkg::NUM_LANES-1:0][PW-1:0] prod_comb;
    logic [LAST:1][muldiv_pkg::NUM_LANES-1:0][PW-1:0] prod_q;

    assign enable   = out_ready || !valid_q[LAST];
    assign in_ready = enable;

    // Low product ignores signedness, so only the high forms matter here
    assign a_signed = (req.op.mul.sel != muldiv_pkg::MUL_HUU);
    assign b_signed = (req.op.mul.sel == muldiv_pkg::MUL_HSS);

    always_comb begin
        for (int i = 0; i < muldiv_pkg::NUM_LANES; i++) begin
            prod_comb[i] = $signed(a_q[i]) * $signed(b_q[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= '0;
        end else if (enable) begin
            valid_q <= {valid_q[LAST-1:0], in_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            tag_q[0]  <= req.tag;
            high_q[0] <= (req.op.mul.sel != muldiv_pkg::MUL_LO);
            for (int i = 0; i < muldiv_pkg::NUM_LANES; i++) begin
                a_q[i] <= {a_signed && req.rs1_data[i][XW-1], req.rs1_data[i]};
                b_q[i] <= {b_signed && req.rs2_data[i][XW-1], req.rs2_data[i]};
            end
            for (int s = 1; s <= LAST; s++) begin
                tag_q[s]  <= tag_q[s-1];
                high_q[s] <= high_q[s-1];
            end
            prod_q[1] <= prod_comb;
            for (int s = 2; s <= LAST; s++) begin
                prod_q[s] <= prod_q[s-1];
            end
        end
    end

    assign out_valid = valid_q[LAST];
    assign rsp.tag   = tag_q[LAST];

    always_comb begin
        for (int i = 0; i < muldiv_pkg::NUM_LANES; i++) begin
            rsp.data[i] = high_q[LAST] ? prod_q[LAST][i][2*XW-1:XW]
                                       : prod_q[LAST][i][XW-1:0];
        end
    end

endmodule

// File: rtl/commit_arbiter.sv
//////////////////////////////////////////////////////////////////////
// Two-input round-robin arbiter with a one-entry output register.
// Input 1 wins the first contested grant after reset.
// in_ready depends on in_valid of both inputs.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module commit_arbiter (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [1:0]                     in_valid,
    output logic [1:0]                     in_ready,
    input  muldiv_pkg::commit_rsp_t [1:0]  in_rsp,
    output logic                           out_valid,
    input  logic                           out_ready,
    output muldiv_pkg::commit_rsp_t        out_rsp
);

    logic       can_load;
    logic       prio;
    logic [1:0] grant;

    muldiv_pkg::commit_rsp_t out_rsp_q;
    logic                    out_valid_q;

    assign can_load = !out_valid_q || out_ready;

    // prio set means input 1 wins when both request
    assign grant[0] = in_valid[0] && (!in_valid[1] || !prio);
    assign grant[1] = in_valid[1] && (!in_valid[0] || prio);

    assign in_ready = can_load ? grant : 2'b00;

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid_q <= 1'b0;
            prio        <= 1'b1;
        end else if (can_load) begin
            out_valid_q <= |in_valid;
            if (&in_valid) begin
                prio <= !prio;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (can_load && (|in_valid)) begin
            out_rsp_q <= grant[1] ? in_rsp[1] : in_rsp[0];
        end
    end

    assign out_valid = out_valid_q;
    assign out_rsp   = out_rsp_q;

endmodule

// File: rtl/muldiv_unit.sv
//////////////////////////////////////////////////////////////////////
// Multiply/divide execute unit with valid/ready on both sides.
// The tag is returned unchanged; results may leave out of order,
// so the issue side must not rely on request order at commit.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module muldiv_unit (
    input  logic                     clk,
    input  logic                     reset,

    input  logic                     req_valid,
    output logic                     req_ready,
    input  muldiv_pkg::muldiv_req_t  req,

    output logic                     rsp_valid,
    input  logic                     rsp_ready,
    output muldiv_pkg::commit_rsp_t  rsp
);

    logic is_div;

    logic mul_in_valid;
    logic mul_in_ready;
    logic div_in_valid;
    logic div_in_ready;

    // Index 0 carries the multiplier, index 1 the divider
    logic [1:0]                          arb_valid;
    logic [1:0]                          arb_ready;
    muldiv_pkg::commit_rsp_t [1:0]       arb_rsp;

    // Class bit sits in the same place in both views of the opcode
    assign is_div = req.op.div.is_div;

    assign mul_in_valid = req_valid && !is_div;
    assign div_in_valid = req_valid && is_div;

    assign req_ready = is_div ? div_in_ready : mul_in_ready;

    pipe_multiplier u_multiplier (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (mul_in_valid),
        .in_ready  (mul_in_ready),
        .req       (req),
        .out_valid (arb_valid[0]),
        .out_ready (arb_ready[0]),
        .rsp       (arb_rsp[0])
    );

    serial_divider u_divider (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (div_in_valid),
        .in_ready  (div_in_ready),
        .req       (req),
        .out_valid (arb_valid[1]),
        .out_ready (arb_ready[1]),
        .rsp       (arb_rsp[1])
    );

    commit_arbiter u_arbiter (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (arb_valid),
        .in_ready  (arb_ready),
        .in_rsp    (arb_rsp),
        .out_valid (rsp_valid),
        .out_ready (rsp_ready),
        .out_rsp   (rsp)
    );

endmodule

// File: tests/muldiv_asserts.sv
//////////////////////////////////////////////////////////////////////
// Handshake assertions, bound into every muldiv_unit instance.
// assert_fails counts failures so the testbench can read them.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module muldiv_asserts (
    input logic                     clk,
    input logic                     reset,
    input logic                     req_valid,
    input logic                     req_ready,
    input logic                     is_div,
    input logic                     div_out_valid,
    input logic                     div_out_ready,
    input logic                     rsp_valid,
    input logic                     rsp_ready,
    input muldiv_pkg::commit_rsp_t  rsp
);

    int   assert_fails = 0;
    logic div_open;

    // A divide stays open from its accept until the divider hands its result on
    always_ff @(posedge clk) begin
        if (reset) begin
            div_open <= 1'b0;
        end else if (req_valid && req_ready && is_div) begin
            div_open <= 1'b1;
        end else if (div_out_valid && div_out_ready) begin
            div_open <= 1'b0;
        end
    end

    rsp_hold: assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else begin
            $error("rsp changed while waiting to be accepted");
            assert_fails++;
        end

    div_ready: assert property (@(posedge clk) disable iff (reset)
        req_ready && is_div |-> !div_open)
        else begin
            $error("req_ready high toward a busy divider");
            assert_fails++;
        end

    rsp_cleared: assert property (@(posedge clk) reset |=> !rsp_valid)
        else begin
            $error("rsp_valid high in the cycle after reset");
            assert_fails++;
        end

endmodule

bind muldiv_unit muldiv_asserts u_asserts (
    .clk           (clk),
    .reset         (reset),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .is_div        (is_div),
    .div_out_valid (arb_valid[1]),
    .div_out_ready (arb_ready[1]),
    .rsp_valid     (rsp_valid),
    .rsp_ready     (rsp_ready),
    .rsp           (rsp)
);

// File: tests/muldiv_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for muldiv_unit. Each request in flight owns a distinct
// destination register, which keys the scoreboard since results
// may come back out of order.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module muldiv_tb;

    localparam int XW         = muldiv_pkg::XLEN;
    localparam int RB         = muldiv_pkg::REG_BITS;
    localparam int TOTAL_REQS = 2 * 4 * 6 * 6 + 2 * 200 + 8 + 3;

    logic                    clk;
    logic                    reset;
    logic                    req_valid;
    logic                    req_ready;
    logic                    rsp_valid;
    logic                    rsp_ready;
    muldiv_pkg::muldiv_req_t req;
    muldiv_pkg::commit_rsp_t rsp;

    integer        seed;
    integer        bp_seed;
    int            cyc = 0;
    int            errors = 0;
    int            checks = 0;
    int            outstanding = 0;
    int            n_req = 0;
    int            n_rsp = 0;
    int            last_acc;
    bit            bp_on = 1'b0;
    bit            hold_rsp = 1'b0;
    bit            lat_on = 1'b0;
    logic [RB-1:0] next_rd = '0;
    logic [XW-1:0] corners [5];

    muldiv_pkg::commit_rsp_t exp_rsp [muldiv_pkg::NUM_REGS];
    bit                      pending [muldiv_pkg::NUM_REGS];
    int                      acc_cyc [muldiv_pkg::NUM_REGS];

    tb_clock u_clock (
        .clk (clk)
    );

    muldiv_unit DUT (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // Expected result of one lane, straight from the RISC-V M rules
    function automatic logic [XW-1:0] muldiv_ref(input logic [2:0] op,
                                                 input logic [XW-1:0] a,
                                                 input logic [XW-1:0] b);
        logic [63:0]          sa;
        logic [63:0]          sb;
        logic [63:0]          ua;
        logic [63:0]          ub;
        logic [63:0]          prod;
        logic signed [XW-1:0] quo_s;
        logic signed [XW-1:0] rem_s;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        ua = {32'b0, a};
        ub = {32'b0, b};
        if (b == '0) begin
            quo_s = '1;
            rem_s = a;
        end else if (a == 32'h8000_0000 && b == '1) begin
            quo_s = a;
            rem_s = '0;
        end else begin
            quo_s = $signed(a) / $signed(b);
            rem_s = $signed(a) % $signed(b);
        end
        prod = ua * ub;
        case (op)
            3'b000: return prod[31:0];
            3'b001: prod = sa * sb;
            3'b010: prod = sa * ub;
            3'b011: prod = ua * ub;
            3'b100: return quo_s;
            3'b101: return (b == '0) ? '1 : a / b;
            3'b110: return rem_s;
            default: return (b == '0) ? a : a % b;
        endcase
        return prod[63:32];
    endfunction

    function automatic logic [XW-1:0] pick(input int k);
        return (k < 5) ? corners[k] : $random(seed);
    endfunction

    function automatic muldiv_pkg::lane_data_t rand_lanes();
        return {pick($unsigned($random(seed)) % 8), pick($unsigned($random(seed)) % 8)};
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            $display("FAILED %s: expected %h, got %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic issue(input logic [2:0] op, input muldiv_pkg::lane_data_t a,
                         input muldiv_pkg::lane_data_t b);
        muldiv_pkg::muldiv_req_t r;
        muldiv_pkg::commit_rsp_t e;
        logic [31:0]             rnd;
        @(negedge clk);
        while (pending[next_rd]) begin
            next_rd = next_rd + 1'b1;
        end
        rnd        = $random(seed);
        r.tag      = rnd[$bits(muldiv_pkg::muldiv_tag_t)-1:0];
        r.tag.rd   = next_rd;
        r.op       = op;
        r.rs1_data = a;
        r.rs2_data = b;
        e.tag      = r.tag;
        for (int i = 0; i < muldiv_pkg::NUM_LANES; i++) begin
            e.data[i] = muldiv_ref(op, a[i], b[i]);
        end
        req       = r;
        req_valid = 1'b1;
        #1;
        while (!req_ready) begin
            @(negedge clk);
            #1;
        end
        // Accepted on the coming rising edge
        exp_rsp[next_rd] = e;
        pending[next_rd] = 1'b1;
        acc_cyc[next_rd] = cyc + 1;
        last_acc         = cyc + 1;
        outstanding++;
        n_req++;
        next_rd = next_rd + 1'b1;
    endtask

    task automatic finish_test(input string name, input int err_mark);
        @(negedge clk);
        req_valid = 1'b0;
        while (outstanding != 0) begin
            @(negedge clk);
        end
        $display("Test %s finished with %0d errors", name, errors - err_mark);
    endtask

    initial begin
        rsp_ready = 1'b1;
        forever begin
            @(negedge clk);
            if (hold_rsp) begin
                rsp_ready = 1'b0;
            end else begin
                rsp_ready = bp_on ? $random(bp_seed) : 1'b1;
            end
        end
    end

    // Scoreboard compare, sampled between the falling and rising edge
    initial begin
        logic [RB-1:0] rd;
        forever begin
            @(negedge clk);
            #2;
            if (rsp_valid && rsp_ready) begin
                rd = rsp.tag.rd;
                n_rsp++;
                if (!pending[rd]) begin
                    $display("Response for register %0d arrived with no request pending", rd);
                    errors++;
                end else begin
                    check_value("rsp.tag", exp_rsp[rd].tag, rsp.tag);
                    check_value("rsp.data[0]", exp_rsp[rd].data[0], rsp.data[0]);
                    check_value("rsp.data[1]", exp_rsp[rd].data[1], rsp.data[1]);
                    if (lat_on) begin
                        check_value("rsp latency", muldiv_pkg::MUL_LATENCY + 1,
                                    cyc + 1 - acc_cyc[rd]);
                    end
                    pending[rd] = 1'b0;
                    outstanding--;
                end
            end
        end
    end

    initial begin
        repeat (TOTAL_REQS * (muldiv_pkg::DIV_CYCLES + 10)) @(posedge clk);
        $display("Watchdog expired with %0d responses outstanding", outstanding);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int                     err_mark;
        int                     prev_acc;
        logic [31:0]            rnd;
        muldiv_pkg::lane_data_t a;
        muldiv_pkg::lane_data_t b;
        seed      = 7108;
        bp_seed   = seed;
        corners   = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        // Multiply then divide corners over every operand pair
        for (int cls = 0; cls < 2; cls++) begin
            err_mark = errors;
            for (int op = 0; op < 4; op++) begin
                for (int i = 0; i < 6; i++) begin
                    for (int j = 0; j < 6; j++) begin
                        a = {pick(j), pick(i)};
                        b = {pick(5 - i), pick(j)};
                        issue(3'(cls * 4 + op), a, b);
                    end
                end
            end
            finish_test(cls == 0 ? "multiply corners" : "divide corners", err_mark);
        end

        for (int pass = 0; pass < 2; pass++) begin
            err_mark = errors;
            bp_on    = (pass == 1);
            for (int k = 0; k < 200; k++) begin
                rnd = $random(seed);
                issue(rnd[2:0], rand_lanes(), rand_lanes());
            end
            finish_test(pass == 0 ? "random stream" : "back-pressure", err_mark);
            check_value("response count", n_req, n_rsp);
        end
        bp_on = 1'b0;

        err_mark = errors;
        lat_on   = 1'b1;
        for (int k = 0; k < 8; k++) begin
            issue(3'(k % 4), rand_lanes(), rand_lanes());
            if (k > 0) begin
                check_value("req accept cycle", prev_acc + 1, last_acc);
            end
            prev_acc = last_acc;
        end
        finish_test("multiply pipelining", err_mark);
        lat_on = 1'b0;

        // Reset while a result waits at the output and a divide is running
        err_mark = errors;
        hold_rsp = 1'b1;
        issue(3'b001, rand_lanes(), rand_lanes());
        issue(3'b100, rand_lanes(), rand_lanes());
        @(negedge clk);
        req_valid = 1'b0;
        while (!rsp_valid) begin
            @(negedge clk);
        end
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset    = 1'b0;
        hold_rsp = 1'b0;
        // Requests caught by the reset never complete
        for (int k = 0; k < muldiv_pkg::NUM_REGS; k++) begin
            pending[k] = 1'b0;
        end
        outstanding = 0;
        #1;
        check_value("rsp_valid", 1'b0, rsp_valid);
        issue(3'b100, {32'h8000_0000, 32'd100}, {32'hffff_ffff, 32'd7});
        finish_test("reset", err_mark);

        errors += DUT.u_asserts.assert_fails;
        $display("Checks: %0d, errors: %0d, requests: %0d", checks, errors, n_req);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: tests/tb_clock.sv
//////////////////////////////////////////////////////////////////////
// Free-running testbench clock, 8 ns period, starting low.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clock #(
    parameter real PERIOD = 8.0
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

endmodule

// File: vlog.f
common/muldiv_pkg.sv
multiplier/pipe_multiplier.sv
divider/serial_divider.sv
rtl/commit_arbiter.sv
rtl/muldiv_unit.sv
tests/tb_clock.sv
tests/muldiv_asserts.sv
tests/muldiv_tb.sv
